/* Bender.yml */
package:
  name: msp430Periph

sources:
  - include_dirs:
      - src
    files:
      - src/periphPkg.sv
      - src/gpioPort.sv
      - src/timerA.sv
      - src/pinMux.sv
      - src/periphTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tbPeriphTop.sv

/* msp430Periph.f */
+incdir+src
src/periphPkg.sv
src/gpioPort.sv
src/timerA.sv
src/pinMux.sv
src/periphTop.sv
testbench/tbPeriphTop.sv

/* src/gpioPort.sv */
/*
    16-bit GPIO port with OUT, DIR, REN, SEL0 and SEL1 registers and a
    synchronized IN register. Reads are combinational and zero off-range.
*/
`default_nettype none

`include "periph_defines.svh"

module gpioPort import periphPkg::*; (
    input  wire logic    SysClock,
    input  wire logic    arstN,
    input  wire addrWord addr,
    input  wire dataWord wrData,
    input  wire logic    memWrite,
    input  wire logic    byteWrite,
    input  wire logic [15:0] portIn,
    output dataWord      rdData,
    output logic [15:0]  portOut,
    output logic [15:0]  portDir,
    output logic [15:0]  portRen,
    output pinSel        portSel [16]
);

    addrWord ofs;
    addrWord regOfs;
    logic    portHit;
    dataWord wrMerged;
    logic [15:0] sel0Reg;
    logic [15:0] sel1Reg;
    logic [15:0] inMeta;
    logic [15:0] inSync;

    assign ofs = addr - `PORT_BASE;
    assign regOfs = {ofs[`PERIPH_ADDR_W-1:1], 1'b0};
    // addresses below the base wrap to large offsets
    assign portHit = (regOfs <= `PORT_SEL1_OFS);

    always_comb begin
        wrMerged = wrData;
        unique case (regOfs)
            `PORT_OUT_OFS:  wrMerged = laneMerge(portOut, wrData, byteWrite, addr[0]);
            `PORT_DIR_OFS:  wrMerged = laneMerge(portDir, wrData, byteWrite, addr[0]);
            `PORT_REN_OFS:  wrMerged = laneMerge(portRen, wrData, byteWrite, addr[0]);
            `PORT_SEL0_OFS: wrMerged = laneMerge(sel0Reg, wrData, byteWrite, addr[0]);
            `PORT_SEL1_OFS: wrMerged = laneMerge(sel1Reg, wrData, byteWrite, addr[0]);
            default:        wrMerged = wrData;
        endcase
    end

    // IN is read-only, so no write case for it
    always_ff @(posedge SysClock or negedge arstN) begin
        if (!arstN) begin
            portOut <= '0;
            portDir <= '0;
            portRen <= '0;
            sel0Reg <= '0;
            sel1Reg <= '0;
        end else if (memWrite) begin
            case (regOfs)
                `PORT_OUT_OFS:  portOut <= wrMerged;
                `PORT_DIR_OFS:  portDir <= wrMerged;
                `PORT_REN_OFS:  portRen <= wrMerged;
                `PORT_SEL0_OFS: sel0Reg <= wrMerged;
                `PORT_SEL1_OFS: sel1Reg <= wrMerged;
                default: ;
            endcase
        end
    end

    // two-flop synchronizer on the pads
    always_ff @(posedge SysClock or negedge arstN) begin
        if (!arstN) begin
            inMeta <= '0;
            inSync <= '0;
        end else begin
            inMeta <= portIn;
            inSync <= inMeta;
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            portSel[i] = pinSel'({sel1Reg[i], sel0Reg[i]});
        end
    end

    always_comb begin
        rdData = '0;
        if (portHit) begin
            case (regOfs)
                `PORT_IN_OFS:   rdData = inSync;
                `PORT_OUT_OFS:  rdData = portOut;
                `PORT_DIR_OFS:  rdData = portDir;
                `PORT_REN_OFS:  rdData = portRen;
                `PORT_SEL0_OFS: rdData = sel0Reg;
                `PORT_SEL1_OFS: rdData = sel1Reg;
                default:        rdData = '0;
            endcase
        end
    end

    // master must not write undefined data into the port
    wrDataKnown: assert property (@(posedge SysClock) disable iff (!arstN)
        (memWrite && portHit) |-> !$isunknown(wrData));

endmodule

`default_nettype wire

/* src/periphPkg.sv */
/*
    Shared bus, pin-select and timer-mode types of the peripheral block,
    plus the byte-lane merge used by every register write.
*/
`default_nettype none

`include "periph_defines.svh"

package periphPkg;

    typedef logic [`PERIPH_DATA_W-1:0] dataWord;
    typedef logic [`PERIPH_ADDR_W-1:0] addrWord;

    // {SEL1, SEL0} of one pin
    typedef enum logic [1:0] {selGpio, selAlt1, selAlt2, selAlt3} pinSel;

    // code 2'b11 acts as stop
    typedef enum logic [1:0] {modeStop, modeUp, modeCont} timerMode;

    // byte writes take the low byte of the bus, lane picked by addr bit 0
    function automatic dataWord laneMerge(dataWord oldVal, dataWord newVal,
                                          logic byteMode, logic highLane);
        dataWord merged;
        merged = oldVal;
        if (!byteMode) begin
            merged = newVal;
        end else if (highLane) begin
            merged[`PERIPH_DATA_W-1:8] = newVal[7:0];
        end else begin
            merged[7:0] = newVal[7:0];
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

/* src/periphTop.sv */
/*
    Peripheral top: one GPIO port, one Timer_A and the pad mux.
    Both register blocks share the bus; their read data is ORed together.
*/
`default_nettype none

`include "periph_defines.svh"

module periphTop import periphPkg::*; (
    input  wire logic    SysClock,
    input  wire logic    arstN,
    input  wire addrWord addr,
    input  wire dataWord wrData,
    input  wire logic    memWrite,
    input  wire logic    byteWrite,
    input  wire logic [15:0] padIn,
    output dataWord      rdData,
    output logic [15:0]  padOut,
    output logic [15:0]  padOe,
    output logic [15:0]  padPullEn
);

    dataWord     portRd;
    dataWord     timerRd;
    logic [15:0] portOut;
    logic [15:0] portDir;
    logic [15:0] portRen;
    pinSel       portSel [16];
    logic [`TIMER_CCM_COUNT-1:0] timerOut;

    gpioPort u_gpioPort (
        .SysClock(SysClock), .arstN(arstN),
        .addr(addr), .wrData(wrData), .memWrite(memWrite), .byteWrite(byteWrite),
        .portIn(padIn), .rdData(portRd),
        .portOut(portOut), .portDir(portDir), .portRen(portRen), .portSel(portSel)
    );

    timerA u_timerA (
        .SysClock(SysClock), .arstN(arstN),
        .addr(addr), .wrData(wrData), .memWrite(memWrite), .byteWrite(byteWrite),
        .rdData(timerRd), .timerOut(timerOut)
    );

    pinMux u_pinMux (
        .portOut(portOut), .portDir(portDir), .portRen(portRen), .portSel(portSel),
        .timerOut(timerOut),
        .padOut(padOut), .padOe(padOe), .padPullEn(padPullEn)
    );

    // each block returns zero outside its own range
    assign rdData = portRd | timerRd;

endmodule

`default_nettype wire

/* src/periph_defines.svh */
/*
    Bus widths, base addresses and register offsets of the peripheral block.
    Included by the package, the RTL and the testbench.
*/
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

`define PERIPH_DATA_W 16
`define PERIPH_ADDR_W 16

`define PORT_BASE 16'h0200
`define TIMER_BASE 16'h0340

// port registers, byte offsets from PORT_BASE
`define PORT_IN_OFS 16'h0000
`define PORT_OUT_OFS 16'h0002
`define PORT_DIR_OFS 16'h0004
`define PORT_REN_OFS 16'h0006
`define PORT_SEL0_OFS 16'h0008
`define PORT_SEL1_OFS 16'h000A

// timer registers, CCR1 and CCR2 follow CCR0 word by word
`define TIMER_CTL_OFS 16'h0000
`define TIMER_TAR_OFS 16'h0010
`define TIMER_CCR0_OFS 16'h0012
`define TIMER_CCM_COUNT 3

`define TIMER_MODE_LSB 4
`define TIMER_CLR_BIT 2

`endif

/* src/pinMux.sv */
/*
    Per-pad function select between GPIO and the timer outputs.
    Purely combinational; pull enable only applies to pads not driven.
*/
`default_nettype none

`include "periph_defines.svh"

module pinMux import periphPkg::*; (
    input  wire logic [15:0] portOut,
    input  wire logic [15:0] portDir,
    input  wire logic [15:0] portRen,
    input  wire pinSel       portSel [16],
    input  wire logic [`TIMER_CCM_COUNT-1:0] timerOut,
    output logic [15:0]      padOut,
    output logic [15:0]      padOe,
    output logic [15:0]      padPullEn
);

    // pins that have a function, indexed by selection
    localparam logic [15:0] funcPins [4] = '{16'hFFFF, 16'h0003, 16'h0000, 16'h00E0};

    logic [15:0] funcOut [4];

    // alt1: TA out1/out2 on pins 0,1; alt3: TA out0..out2 on pins 5..7
    always_comb begin
        funcOut[0] = portOut;
        funcOut[1] = {14'b0, timerOut[2], timerOut[1]};
        funcOut[2] = '0;
        funcOut[3] = {8'b0, timerOut[2], timerOut[1], timerOut[0], 5'b0};
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            padOut[i] = funcOut[portSel[i]][i] & funcPins[portSel[i]][i];
            padOe[i] = portDir[i] & funcPins[portSel[i]][i];
            padPullEn[i] = portRen[i] & ~padOe[i];
        end
    end

    // no pad drives under a selection without a function
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            noFuncOff: assert final (!padOe[i] ||
                (portSel[i] == selGpio) ||
                ((portSel[i] == selAlt1) && (i < 2)) ||
                ((portSel[i] == selAlt3) && (i >= 5) && (i <= 7)));
        end
    end

endmodule

`default_nettype wire

/* src/timerA.sv */
/*
    Timer_A with CTL, TAR and CCR0..CCR2. Counts on SysClock in stop, up
    or continuous mode; each compare unit toggles its output on a match.
*/
`default_nettype none

`include "periph_defines.svh"

module timerA import periphPkg::*; (
    input  wire logic    SysClock,
    input  wire logic    arstN,
    input  wire addrWord addr,
    input  wire dataWord wrData,
    input  wire logic    memWrite,
    input  wire logic    byteWrite,
    output dataWord      rdData,
    output logic [`TIMER_CCM_COUNT-1:0] timerOut
);

    addrWord  ofs;
    addrWord  regOfs;
    logic     wrCtl;
    logic     wrTar;
    logic     clrReq;
    logic [`TIMER_CCM_COUNT-1:0] wrCcr;
    dataWord  ctlNext;
    dataWord  ctl;
    dataWord  tar;
    dataWord  ccr [`TIMER_CCM_COUNT];
    timerMode mode;
    logic     running;

    assign ofs = addr - `TIMER_BASE;
    assign regOfs = {ofs[`PERIPH_ADDR_W-1:1], 1'b0};

    assign wrCtl = memWrite && (regOfs == `TIMER_CTL_OFS);
    assign wrTar = memWrite && (regOfs == `TIMER_TAR_OFS);

    always_comb begin
        for (int i = 0; i < `TIMER_CCM_COUNT; i++) begin
            wrCcr[i] = memWrite && (regOfs == `TIMER_CCR0_OFS + addrWord'(2 * i));
        end
    end

    assign ctlNext = laneMerge(ctl, wrData, byteWrite, addr[0]);
    assign clrReq = wrCtl && ctlNext[`TIMER_CLR_BIT];

    assign mode = timerMode'(ctl[`TIMER_MODE_LSB +: 2]);
    assign running = (mode == modeUp) || (mode == modeCont);

    // clear bit is a strobe and is never stored
    always_ff @(posedge SysClock or negedge arstN) begin
        if (!arstN) begin
            ctl <= '0;
        end else if (wrCtl) begin
            ctl <= ctlNext;
            ctl[`TIMER_CLR_BIT] <= 1'b0;
        end
    end

    always_ff @(posedge SysClock or negedge arstN) begin
        if (!arstN) begin
            tar <= '0;
        end else if (clrReq) begin
            tar <= '0;
        end else if (wrTar) begin
            tar <= laneMerge(tar, wrData, byteWrite, addr[0]);
        end else begin
            case (mode)
                // >= so a TAR left above CCR0 still falls back to 0
                modeUp:   tar <= (tar >= ccr[0]) ? '0 : tar + 16'd1;
                modeCont: tar <= tar + 16'd1;
                default:  tar <= tar;
            endcase
        end
    end

    always_ff @(posedge SysClock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `TIMER_CCM_COUNT; i++) begin
                ccr[i] <= '0;
            end
            timerOut <= '0;
        end else begin
            for (int i = 0; i < `TIMER_CCM_COUNT; i++) begin
                if (wrCcr[i]) begin
                    ccr[i] <= laneMerge(ccr[i], wrData, byteWrite, addr[0]);
                end
                if (running && (tar == ccr[i])) begin
                    timerOut[i] <= ~timerOut[i];
                end
            end
        end
    end

    always_comb begin
        rdData = '0;
        if (regOfs == `TIMER_CTL_OFS) begin
            rdData = ctl;
        end else if (regOfs == `TIMER_TAR_OFS) begin
            rdData = tar;
        end else begin
            for (int i = 0; i < `TIMER_CCM_COUNT; i++) begin
                if (regOfs == `TIMER_CCR0_OFS + addrWord'(2 * i)) begin
                    rdData = ccr[i];
                end
            end
        end
    end

    // a mode switch or a TAR/CCR0 write may leave TAR past CCR0 for one cycle
    upModeBound: assert property (@(posedge SysClock) disable iff (!arstN)
        (mode == modeUp) && !$past(wrCtl || wrTar || wrCcr[0]) |-> (tar <= ccr[0]));

    clrReadsZero: assert property (@(posedge SysClock) disable iff (!arstN)
        (regOfs == `TIMER_CTL_OFS) |-> !rdData[`TIMER_CLR_BIT]);

endmodule

`default_nettype wire

/* testbench/tbPeriphTop.sv */
/*
    Table-driven testbench for periphTop. The stimulus table and its expected
    values are built at time zero, then applied one entry at a time after reset.
*/
`default_nettype none

`include "periph_defines.svh"

module tbPeriphTop;
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [1:0] {opWrite, opRead, opPad, opWait} opKind;

    // pad entries: addr picks padOut/padOe/padPullEn, data is the pin mask
    // wait entries: data is the new padIn value
    typedef struct packed {
        opKind       op;
        logic [15:0] addr;
        logic [15:0] data;
        logic        bw;
        logic [15:0] expected;
        logic [7:0]  waitCycles;
    } tblEntry;

    localparam logic [15:0] regIn = `PORT_BASE + `PORT_IN_OFS;
    localparam logic [15:0] regOut = `PORT_BASE + `PORT_OUT_OFS;
    localparam logic [15:0] regDir = `PORT_BASE + `PORT_DIR_OFS;
    localparam logic [15:0] regRen = `PORT_BASE + `PORT_REN_OFS;
    localparam logic [15:0] regSel0 = `PORT_BASE + `PORT_SEL0_OFS;
    localparam logic [15:0] regSel1 = `PORT_BASE + `PORT_SEL1_OFS;
    localparam logic [15:0] regCtl = `TIMER_BASE + `TIMER_CTL_OFS;
    localparam logic [15:0] regTar = `TIMER_BASE + `TIMER_TAR_OFS;
    localparam logic [15:0] regCcr0 = `TIMER_BASE + `TIMER_CCR0_OFS;
    localparam logic [15:0] clrBit = 16'd1 << `TIMER_CLR_BIT;
    localparam logic [15:0] upBits = 16'd1 << `TIMER_MODE_LSB;
    localparam logic [15:0] contBits = 16'd2 << `TIMER_MODE_LSB;

    logic        SysClock = 1'b0;
    logic        arstN;
    logic [15:0] addr;
    logic [15:0] wrData;
    logic        memWrite;
    logic        byteWrite;
    logic [15:0] padIn;
    logic [15:0] rdData;
    logic [15:0] padOut;
    logic [15:0] padOe;
    logic [15:0] padPullEn;

    tblEntry     tbl [$];
    int          tNow = 0;
    logic [15:0] padNow = '0;
    integer      seed = 32'hcc6dcddd;
    int          errors = 0;
    int          checks = 0;
    int          cycleLimit = 0;
    int          cycleCount = 0;

    always #10 SysClock = ~SysClock;

    periphTop u_periphTop (
        .SysClock(SysClock), .arstN(arstN),
        .addr(addr), .wrData(wrData), .memWrite(memWrite), .byteWrite(byteWrite),
        .padIn(padIn), .rdData(rdData),
        .padOut(padOut), .padOe(padOe), .padPullEn(padPullEn)
    );

    task automatic checkValue(string name, logic [15:0] expected, logic [15:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s at %0t: expected %h, got %h", name, $time, expected, actual);
        end
    endtask

    // tNow tracks the clock edge on which the next entry is driven
    task automatic addEntry(opKind op, logic [15:0] a, logic [15:0] d, logic bw,
                            logic [15:0] e, int w);
        tblEntry ent;
        ent.op = op;
        ent.addr = a;
        ent.data = d;
        ent.bw = bw;
        ent.expected = e;
        ent.waitCycles = w[7:0];
        tbl.push_back(ent);
        tNow = tNow + 1 + w;
    endtask

    task automatic writeReg(logic [15:0] a, logic [15:0] d, logic bw);
        addEntry(opWrite, a, d, bw, 16'h0, 0);
    endtask

    task automatic readReg(logic [15:0] a, logic [15:0] e);
        addEntry(opRead, a, 16'h0, 1'b0, e, 0);
    endtask

    task automatic padCheck(int sel, logic [15:0] mask, logic [15:0] e, int w);
        addEntry(opPad, 16'(sel), mask, 1'b0, e, w);
    endtask

    task automatic idleCycles(int w);
        addEntry(opWait, 16'h0, padNow, 1'b0, 16'h0, w);
    endtask

    // output level after j running cycles, toggled when the count passed c
    function automatic logic toggleLevel(int j, int c);
        if (j - 1 < c) begin
            return 1'b0;
        end
        return 1'(((j - 1 - c) / 10 + 1) % 2);
    endfunction

    task automatic buildTable();
        logic [15:0] regList [9];
        logic [15:0] w;
        logic [15:0] b;
        logic [15:0] v;
        logic [15:0] outVal;
        logic [15:0] dirVal;
        logic [15:0] renVal;
        logic [15:0] padExp;
        int          i;
        int          j;
        int          c1;
        int          c2;
        int          tStart;
        int          tCont;
        int          tStop;
        regList = '{regOut, regDir, regRen, regSel0, regSel1,
                    regCcr0, regCcr0 + 16'd2, regCcr0 + 16'd4, regTar};

        // reset state
        for (i = 0; i < 9; i++) begin
            readReg(regList[i], 16'h0);
        end
        readReg(regIn, 16'h0);
        readReg(regCtl, 16'h0);
        padCheck(0, 16'hFFFF, 16'h0, 0);
        padCheck(1, 16'hFFFF, 16'h0, 0);
        padCheck(2, 16'hFFFF, 16'h0, 0);

        // word write, then low and high byte lanes
        for (i = 0; i < 9; i++) begin
            w = $random(seed);
            writeReg(regList[i] + 16'(i % 2), w, 1'b0);
            readReg(regList[i], w);
            b = $random(seed);
            writeReg(regList[i], b, 1'b1);
            v = {w[15:8], b[7:0]};
            readReg(regList[i], v);
            b = $random(seed);
            writeReg(regList[i] + 16'd1, b, 1'b1);
            v = {b[7:0], v[7:0]};
            readReg(regList[i], v);
        end
        w = $random(seed);
        writeReg(regIn, w, 1'b0);
        readReg(regIn, 16'h0);

        // GPIO function on every pin
        outVal = $random(seed);
        dirVal = $random(seed);
        renVal = $random(seed);
        writeReg(regSel0, 16'h0, 1'b0);
        writeReg(regSel1, 16'h0, 1'b0);
        writeReg(regOut, outVal, 1'b0);
        writeReg(regDir, dirVal, 1'b0);
        writeReg(regRen, renVal, 1'b0);
        padCheck(0, 16'hFFFF, outVal, 0);
        padCheck(1, 16'hFFFF, dirVal, 0);
        padCheck(2, 16'hFFFF, renVal & ~dirVal, 0);
        padNow = $random(seed);
        idleCycles(3);
        readReg(regIn, padNow);

        // up mode, pins 5..8 on alt3 and pin 9 on alt2, all with DIR set
        c1 = {$random(seed)} % 10;
        c2 = {$random(seed)} % 10;
        writeReg(regCcr0, 16'd9, 1'b0);
        writeReg(regCcr0 + 16'd2, 16'(c1), 1'b0);
        writeReg(regCcr0 + 16'd4, 16'(c2), 1'b0);
        writeReg(regSel0, 16'h01E0, 1'b0);
        writeReg(regSel1, 16'h03E0, 1'b0);
        writeReg(regDir, 16'h03E0, 1'b0);
        padCheck(1, 16'h03E0, 16'h00E0, 0);
        padCheck(0, 16'h00E0, 16'h0000, 0);
        tStart = tNow;
        writeReg(regCtl, upBits | clrBit, 1'b0);
        for (i = 0; i < 14; i++) begin
            j = tNow - tStart - 1;
            padExp = {8'h0, toggleLevel(j, c2), toggleLevel(j, c1), toggleLevel(j, 9), 5'h0};
            padCheck(0, 16'h00E0, padExp, 4);
        end
        padCheck(1, 16'h03E0, 16'h00E0, 0);
        readReg(regCtl, upBits);

        // continuous mode from a cleared counter, then stop
        tCont = tNow;
        writeReg(regCtl, contBits | clrBit, 1'b0);
        readReg(regCtl, contBits);
        idleCycles(20 + {$random(seed)} % 40);
        readReg(regTar, 16'(tNow - tCont - 1));
        tStop = tNow;
        writeReg(regCtl, 16'h0, 1'b0);
        idleCycles(5);
        readReg(regTar, 16'(tStop - tCont));
        readReg(regTar, 16'(tStop - tCont));
    endtask

    task automatic applyEntry(tblEntry ent);
        @(posedge SysClock);
        addr <= ent.addr;
        wrData <= ent.data;
        byteWrite <= ent.bw;
        memWrite <= (ent.op == opWrite);
        if (ent.op == opWait) begin
            padIn <= ent.data;
        end
        // outputs have settled by the falling edge
        @(negedge SysClock);
        case (ent.op)
            opRead: checkValue("rdData", ent.expected, rdData);
            opPad: begin
                case (ent.addr)
                    16'd0:   checkValue("padOut", ent.expected, padOut & ent.data);
                    16'd1:   checkValue("padOe", ent.expected, padOe & ent.data);
                    default: checkValue("padPullEn", ent.expected, padPullEn & ent.data);
                endcase
            end
            default: ;
        endcase
        repeat (ent.waitCycles) @(posedge SysClock);
    endtask

    initial begin
        int sumWait;
        arstN = 1'b0;
        addr = '0;
        wrData = '0;
        memWrite = 1'b0;
        byteWrite = 1'b0;
        padIn = '0;
        buildTable();
        sumWait = 0;
        foreach (tbl[k]) begin
            sumWait += tbl[k].waitCycles;
        end
        cycleLimit = 2 * (sumWait + tbl.size()) + 100;
        repeat (10) @(posedge SysClock);
        arstN <= 1'b1;
        foreach (tbl[k]) begin
            applyEntry(tbl[k]);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge SysClock);
            cycleCount++;
        end
        $display("timeout: the table did not finish within %0d clock cycles", cycleLimit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
